// File: include/epu_settings.svh
`ifndef EPU_SETTINGS_SVH
`define EPU_SETTINGS_SVH

// AXI port widths
`define EPU_ADDR_BITS 32
`define EPU_DATA_BITS 32
`define EPU_ID_BITS 4
`define EPU_LEN_BITS 8

// Word buffers
`define EPU_BUF_DEPTH 64
`define EPU_BUF_ADDR_BITS 6

// Address map, one region per buffer plus the control block
`define EPU_IN_BASE 32'h5000_0000
`define EPU_OUT_BASE 32'h6000_0000
`define EPU_WEIGHT_BASE 32'h7000_0000
`define EPU_CTRL_BASE 32'h8000_0000
`define EPU_REGION_SPAN 32'h0100_0000

// Only response code
`define EPU_RESP_OKAY 2'b00

`endif

// File: source/epu_pkg.sv
package epu_pkg;

  // Four signed 8-bit lanes, lane 0 in the low byte
  typedef logic [3:0][7:0] quad_t;

  typedef logic signed [31:0] acc_t;

  // One-hot region select
  typedef enum logic [4:0] {
    NONE   = 5'b00001,
    IN     = 5'b00010,
    OUT    = 5'b00100,
    WEIGHT = 5'b01000,
    CTRL   = 5'b10000
  } region_t;

  // bcast picks the w8 register over weight buffer word n
  typedef struct packed {
    logic [1:0] rsvd;
    logic       relu;
    logic       bcast;
  } mode_t;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    R_CH = 2'd1,
    W_CH = 2'd2,
    B_CH = 2'd3
  } slave_state_t;

endpackage

// File: source/epu_buffer.sv
`include "epu_settings.svh"

module epu_buffer #(
  parameter type word_t = epu_pkg::quad_t
) (
  input  logic                          clk,
  input  logic                          rst,
  // Bus side
  input  logic                          bus_sel_i,
  input  logic                          bus_we_i,
  input  logic [`EPU_BUF_ADDR_BITS-1:0] bus_idx_i,
  input  word_t                         bus_wdata_i,
  output word_t                         bus_rdata_o,
  // Engine side, separate read and write indices
  input  logic                          eng_re_i,
  input  logic [`EPU_BUF_ADDR_BITS-1:0] eng_ridx_i,
  input  logic                          eng_we_i,
  input  logic [`EPU_BUF_ADDR_BITS-1:0] eng_widx_i,
  input  word_t                         eng_wdata_i,
  output word_t                         eng_rdata_o
);

  word_t mem [`EPU_BUF_DEPTH];

  always_ff @(posedge clk) begin
    if (bus_sel_i && bus_we_i) begin
      mem[bus_idx_i] <= bus_wdata_i;
    end
    if (eng_we_i) begin
      mem[eng_widx_i] <= eng_wdata_i;
    end
  end

  // Registered reads, each output holds until its next read
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bus_rdata_o <= '0;
      eng_rdata_o <= '0;
    end else begin
      if (bus_sel_i && !bus_we_i) begin
        bus_rdata_o <= mem[bus_idx_i];
      end
      if (eng_re_i) begin
        eng_rdata_o <= mem[eng_ridx_i];
      end
    end
  end

  // Host and engine never write one word together
  assert property (@(posedge clk) disable iff (rst)
    bus_sel_i && bus_we_i && eng_we_i |-> bus_idx_i != eng_widx_i);

endmodule

// File: source/epu_axi_slave.sv
`include "epu_settings.svh"

module epu_axi_slave (
  input  logic                          clk,
  input  logic                          rst,
  // Write address
  input  logic                          awvalid_i,
  output logic                          awready_o,
  input  logic [`EPU_ADDR_BITS-1:0]     awaddr_i,
  input  logic [`EPU_ID_BITS-1:0]       awid_i,
  input  logic [`EPU_LEN_BITS-1:0]      awlen_i,
  input  logic [1:0]                    awburst_i,
  // Write data
  input  logic                          wvalid_i,
  output logic                          wready_o,
  input  logic [`EPU_DATA_BITS-1:0]     wdata_i,
  input  logic                          wlast_i,
  // Write response
  output logic                          bvalid_o,
  input  logic                          bready_i,
  output logic [`EPU_ID_BITS-1:0]       bid_o,
  output logic [1:0]                    bresp_o,
  // Read address
  input  logic                          arvalid_i,
  output logic                          arready_o,
  input  logic [`EPU_ADDR_BITS-1:0]     araddr_i,
  input  logic [`EPU_ID_BITS-1:0]       arid_i,
  input  logic [`EPU_LEN_BITS-1:0]      arlen_i,
  input  logic [1:0]                    arburst_i,
  // Read data
  output logic                          rvalid_o,
  input  logic                          rready_i,
  output logic [`EPU_DATA_BITS-1:0]     rdata_o,
  output logic [`EPU_ID_BITS-1:0]       rid_o,
  output logic [1:0]                    rresp_o,
  output logic                          rlast_o,
  // Input buffer
  output logic                          in_sel_o,
  output logic                          in_we_o,
  output logic [`EPU_BUF_ADDR_BITS-1:0] in_idx_o,
  output epu_pkg::quad_t                in_wdata_o,
  input  epu_pkg::quad_t                in_rdata_i,
  // Weight buffer
  output logic                          wt_sel_o,
  output logic                          wt_we_o,
  output logic [`EPU_BUF_ADDR_BITS-1:0] wt_idx_o,
  output epu_pkg::quad_t                wt_wdata_o,
  input  epu_pkg::quad_t                wt_rdata_i,
  // Output buffer
  output logic                          out_sel_o,
  output logic                          out_we_o,
  output logic [`EPU_BUF_ADDR_BITS-1:0] out_idx_o,
  output epu_pkg::acc_t                 out_wdata_o,
  input  epu_pkg::acc_t                 out_rdata_i,
  // Engine control
  output logic                          start_o,
  output epu_pkg::mode_t                mode_o,
  output epu_pkg::quad_t                w8_o,
  output logic [`EPU_BUF_ADDR_BITS-1:0] count_o,
  input  logic                          busy_i,
  input  logic                          done_i
);

  epu_pkg::slave_state_t             state_q, state_d;
  epu_pkg::region_t                  region, rd_region_q;
  logic [`EPU_ADDR_BITS-1:0]         addr_q, beat_addr;
  logic [`EPU_ID_BITS-1:0]           id_q;
  logic [`EPU_LEN_BITS-1:0]          len_q, cnt_q;
  logic                              aw_hs, ar_hs, w_hs, r_hs, b_hs;
  logic                              rd_issue, rd_pend_q, rvalid_q;
  logic [`EPU_DATA_BITS-1:0]         rdata_q;
  logic                              start_q;
  epu_pkg::mode_t                    mode_q;
  epu_pkg::quad_t                    w8_q;
  logic [`EPU_BUF_ADDR_BITS-1:0]     count_q;

  function automatic epu_pkg::region_t decode(input logic [`EPU_ADDR_BITS-1:0] addr);
    if (addr >= `EPU_IN_BASE && addr < `EPU_IN_BASE + `EPU_REGION_SPAN)
      return epu_pkg::IN;
    if (addr >= `EPU_OUT_BASE && addr < `EPU_OUT_BASE + `EPU_REGION_SPAN)
      return epu_pkg::OUT;
    if (addr >= `EPU_WEIGHT_BASE && addr < `EPU_WEIGHT_BASE + `EPU_REGION_SPAN)
      return epu_pkg::WEIGHT;
    if (addr >= `EPU_CTRL_BASE && addr < `EPU_CTRL_BASE + `EPU_REGION_SPAN)
      return epu_pkg::CTRL;
    return epu_pkg::NONE;
  endfunction

  // Write wins when both address channels arrive together
  assign awready_o = state_q == epu_pkg::IDLE;
  assign arready_o = (state_q == epu_pkg::IDLE) && !awvalid_i;
  assign wready_o  = state_q == epu_pkg::W_CH;
  assign bvalid_o  = state_q == epu_pkg::B_CH;
  assign rvalid_o  = rvalid_q;
  assign rdata_o   = rdata_q;
  assign rlast_o   = (state_q == epu_pkg::R_CH) && (cnt_q == len_q);
  assign bid_o     = id_q;
  assign rid_o     = id_q;
  assign bresp_o   = `EPU_RESP_OKAY;
  assign rresp_o   = `EPU_RESP_OKAY;

  assign aw_hs = awvalid_i && awready_o;
  assign ar_hs = arvalid_i && arready_o;
  assign w_hs  = wvalid_i && wready_o;
  assign r_hs  = rvalid_o && rready_i;
  assign b_hs  = bvalid_o && bready_i;

  // Next read goes out on the AR transfer or on each non-last R transfer
  assign rd_issue = ar_hs || (r_hs && !rlast_o);

  always_comb begin
    if (ar_hs) begin
      beat_addr = araddr_i;
    end else if (state_q == epu_pkg::R_CH) begin
      beat_addr = addr_q + 32'd4;
    end else begin
      beat_addr = addr_q;
    end
  end

  assign region = decode(beat_addr);

  // Beat steering to the buffers
  assign in_sel_o    = (w_hs || rd_issue) && region == epu_pkg::IN;
  assign in_we_o     = w_hs && region == epu_pkg::IN;
  assign in_idx_o    = beat_addr[`EPU_BUF_ADDR_BITS+1:2];
  assign in_wdata_o  = wdata_i;
  assign wt_sel_o    = (w_hs || rd_issue) && region == epu_pkg::WEIGHT;
  assign wt_we_o     = w_hs && region == epu_pkg::WEIGHT;
  assign wt_idx_o    = beat_addr[`EPU_BUF_ADDR_BITS+1:2];
  assign wt_wdata_o  = wdata_i;
  assign out_sel_o   = (w_hs || rd_issue) && region == epu_pkg::OUT;
  assign out_we_o    = w_hs && region == epu_pkg::OUT;
  assign out_idx_o   = beat_addr[`EPU_BUF_ADDR_BITS+1:2];
  assign out_wdata_o = wdata_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      epu_pkg::IDLE: begin
        if (aw_hs) state_d = epu_pkg::W_CH;
        else if (ar_hs) state_d = epu_pkg::R_CH;
      end
      epu_pkg::R_CH: if (r_hs && rlast_o) state_d = epu_pkg::IDLE;
      epu_pkg::W_CH: if (w_hs && wlast_i) state_d = epu_pkg::B_CH;
      epu_pkg::B_CH: if (b_hs) state_d = epu_pkg::IDLE;
      default: state_d = epu_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= epu_pkg::IDLE;
      addr_q  <= '0;
      id_q    <= '0;
      len_q   <= '0;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (aw_hs) addr_q <= awaddr_i;
      else if (rd_issue) addr_q <= beat_addr;
      else if (w_hs) addr_q <= addr_q + 32'd4;
      if (aw_hs) begin
        id_q  <= awid_i;
        len_q <= awlen_i;
      end else if (ar_hs) begin
        id_q  <= arid_i;
        len_q <= arlen_i;
      end
      // Read beat count
      if (ar_hs) cnt_q <= '0;
      else if (r_hs) cnt_q <= cnt_q + 1'b1;
    end
  end

  // Buffer data lands one cycle after the issue, rvalid the cycle after
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_pend_q   <= 1'b0;
      rvalid_q    <= 1'b0;
      rd_region_q <= epu_pkg::NONE;
    end else begin
      rd_pend_q <= rd_issue;
      if (rd_issue) rd_region_q <= region;
      if (rd_pend_q) rvalid_q <= 1'b1;
      else if (r_hs) rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_pend_q) begin
      case (rd_region_q)
        epu_pkg::IN:     rdata_q <= in_rdata_i;
        epu_pkg::WEIGHT: rdata_q <= wt_rdata_i;
        epu_pkg::OUT:    rdata_q <= out_rdata_i;
        epu_pkg::CTRL:   rdata_q <= {{(`EPU_DATA_BITS-1){1'b0}}, busy_i};
        default:         rdata_q <= '0;
      endcase
    end
  end

  // Control registers, mode drops back to zero when a run ends
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      start_q <= 1'b0;
      mode_q  <= '0;
      w8_q    <= '0;
      count_q <= '0;
    end else begin
      start_q <= 1'b0;
      if (done_i) mode_q <= '0;
      if (w_hs && region == epu_pkg::CTRL) begin
        if (addr_q == `EPU_CTRL_BASE) begin
          w8_q <= wdata_i;
        end else if (addr_q == `EPU_CTRL_BASE + 32'd4) begin
          mode_q  <= wdata_i[4:1];
          count_q <= wdata_i[13:8];
          start_q <= wdata_i[0] && !busy_i;
        end
      end
    end
  end

  assign start_o = start_q;
  assign mode_o  = mode_q;
  assign w8_o    = w8_q;
  assign count_o = count_q;

  // A stalled read beat keeps its data
  assert property (@(posedge clk) disable iff (rst)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o));

  // Masters only send INCR bursts
  assert property (@(posedge clk) disable iff (rst)
    aw_hs || ar_hs |-> (aw_hs ? awburst_i : arburst_i) == 2'b01);

endmodule

// File: source/epu_conv_engine.sv
`include "epu_settings.svh"

module epu_conv_engine (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          start_i,
  input  epu_pkg::mode_t                mode_i,
  input  epu_pkg::quad_t                w8_i,
  input  logic [`EPU_BUF_ADDR_BITS-1:0] count_i,
  input  epu_pkg::quad_t                in_rdata_i,
  input  epu_pkg::quad_t                wt_rdata_i,
  output logic                          busy_o,
  output logic                          done_o,
  output logic                          rd_re_o,
  output logic [`EPU_BUF_ADDR_BITS-1:0] rd_idx_o,
  output logic                          wr_we_o,
  output logic [`EPU_BUF_ADDR_BITS-1:0] wr_idx_o,
  output epu_pkg::acc_t                 wr_data_o
);

  logic                          busy_q, iss_q, done_q;
  logic                          v1_q, v2_q, last1_q, last2_q, last0;
  logic [`EPU_BUF_ADDR_BITS-1:0] cnt_q, last_idx_q, idx1_q, idx2_q;
  epu_pkg::quad_t                wt;
  epu_pkg::acc_t                 sum, res_q;

  assign last0 = cnt_q == last_idx_q;

  // Stage 0 issues reads, stage 1 sees data, stage 2 writes, stage 3 signals done
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy_q     <= 1'b0;
      iss_q      <= 1'b0;
      cnt_q      <= '0;
      last_idx_q <= '0;
      v1_q       <= 1'b0;
      v2_q       <= 1'b0;
      last1_q    <= 1'b0;
      last2_q    <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      if (start_i && !busy_q) begin
        busy_q     <= 1'b1;
        iss_q      <= 1'b1;
        cnt_q      <= '0;
        last_idx_q <= count_i;
      end else begin
        if (iss_q && last0) iss_q <= 1'b0;
        if (iss_q) cnt_q <= cnt_q + 1'b1;
        if (v2_q && last2_q) busy_q <= 1'b0;
      end
      v1_q    <= iss_q;
      last1_q <= iss_q && last0;
      v2_q    <= v1_q;
      last2_q <= last1_q;
      done_q  <= v2_q && last2_q;
    end
  end

  // Four-lane signed dot product
  always_comb begin
    wt  = mode_i.bcast ? w8_i : wt_rdata_i;
    sum = '0;
    for (int l = 0; l < 4; l++) begin
      sum = sum + $signed(in_rdata_i[l]) * $signed(wt[l]);
    end
    if (mode_i.relu && sum < 0) begin
      sum = '0;
    end
  end

  always_ff @(posedge clk) begin
    idx1_q <= cnt_q;
    idx2_q <= idx1_q;
    res_q  <= sum;
  end

  assign busy_o    = busy_q;
  assign done_o    = done_q;
  assign rd_re_o   = iss_q;
  assign rd_idx_o  = cnt_q;
  assign wr_we_o   = v2_q;
  assign wr_idx_o  = idx2_q;
  assign wr_data_o = res_q;

  // Control block only starts an idle engine
  assert property (@(posedge clk) disable iff (rst) busy_o |-> !start_i);

endmodule

// File: source/epu_top.sv
`include "epu_settings.svh"

module epu_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      awvalid_i,
  output logic                      awready_o,
  input  logic [`EPU_ADDR_BITS-1:0] awaddr_i,
  input  logic [`EPU_ID_BITS-1:0]   awid_i,
  input  logic [`EPU_LEN_BITS-1:0]  awlen_i,
  input  logic [1:0]                awburst_i,
  input  logic                      wvalid_i,
  output logic                      wready_o,
  input  logic [`EPU_DATA_BITS-1:0] wdata_i,
  input  logic                      wlast_i,
  output logic                      bvalid_o,
  input  logic                      bready_i,
  output logic [`EPU_ID_BITS-1:0]   bid_o,
  output logic [1:0]                bresp_o,
  input  logic                      arvalid_i,
  output logic                      arready_o,
  input  logic [`EPU_ADDR_BITS-1:0] araddr_i,
  input  logic [`EPU_ID_BITS-1:0]   arid_i,
  input  logic [`EPU_LEN_BITS-1:0]  arlen_i,
  input  logic [1:0]                arburst_i,
  output logic                      rvalid_o,
  input  logic                      rready_i,
  output logic [`EPU_DATA_BITS-1:0] rdata_o,
  output logic [`EPU_ID_BITS-1:0]   rid_o,
  output logic [1:0]                rresp_o,
  output logic                      rlast_o,
  output logic                      epuint_o
);

  logic                          in_sel, in_we, wt_sel, wt_we, out_sel, out_we;
  logic [`EPU_BUF_ADDR_BITS-1:0] in_idx, wt_idx, out_idx;
  epu_pkg::quad_t                in_wdata, in_rdata, wt_wdata, wt_rdata;
  epu_pkg::acc_t                 out_wdata, out_rdata;
  logic                          start, busy, done;
  epu_pkg::mode_t                mode;
  epu_pkg::quad_t                w8;
  logic [`EPU_BUF_ADDR_BITS-1:0] count;
  logic                          eng_re, eng_we;
  logic [`EPU_BUF_ADDR_BITS-1:0] eng_ridx, eng_widx;
  epu_pkg::quad_t                eng_in_rdata, eng_wt_rdata;
  epu_pkg::acc_t                 eng_wdata;

  assign epuint_o = done;

  epu_axi_slave i_slave (
    .clk, .rst,
    .awvalid_i, .awready_o, .awaddr_i, .awid_i, .awlen_i, .awburst_i,
    .wvalid_i, .wready_o, .wdata_i, .wlast_i,
    .bvalid_o, .bready_i, .bid_o, .bresp_o,
    .arvalid_i, .arready_o, .araddr_i, .arid_i, .arlen_i, .arburst_i,
    .rvalid_o, .rready_i, .rdata_o, .rid_o, .rresp_o, .rlast_o,
    .in_sel_o    (in_sel),
    .in_we_o     (in_we),
    .in_idx_o    (in_idx),
    .in_wdata_o  (in_wdata),
    .in_rdata_i  (in_rdata),
    .wt_sel_o    (wt_sel),
    .wt_we_o     (wt_we),
    .wt_idx_o    (wt_idx),
    .wt_wdata_o  (wt_wdata),
    .wt_rdata_i  (wt_rdata),
    .out_sel_o   (out_sel),
    .out_we_o    (out_we),
    .out_idx_o   (out_idx),
    .out_wdata_o (out_wdata),
    .out_rdata_i (out_rdata),
    .start_o     (start),
    .mode_o      (mode),
    .w8_o        (w8),
    .count_o     (count),
    .busy_i      (busy),
    .done_i      (done)
  );

  // Input and weight buffers are only read by the engine
  epu_buffer #(.word_t(epu_pkg::quad_t)) i_in_buf (
    .clk         (clk),
    .rst         (rst),
    .bus_sel_i   (in_sel),
    .bus_we_i    (in_we),
    .bus_idx_i   (in_idx),
    .bus_wdata_i (in_wdata),
    .bus_rdata_o (in_rdata),
    .eng_re_i    (eng_re),
    .eng_ridx_i  (eng_ridx),
    .eng_we_i    (1'b0),
    .eng_widx_i  ('0),
    .eng_wdata_i ('0),
    .eng_rdata_o (eng_in_rdata)
  );

  epu_buffer #(.word_t(epu_pkg::quad_t)) i_wt_buf (
    .clk         (clk),
    .rst         (rst),
    .bus_sel_i   (wt_sel),
    .bus_we_i    (wt_we),
    .bus_idx_i   (wt_idx),
    .bus_wdata_i (wt_wdata),
    .bus_rdata_o (wt_rdata),
    .eng_re_i    (eng_re),
    .eng_ridx_i  (eng_ridx),
    .eng_we_i    (1'b0),
    .eng_widx_i  ('0),
    .eng_wdata_i ('0),
    .eng_rdata_o (eng_wt_rdata)
  );

  // Output buffer is only written by the engine
  epu_buffer #(.word_t(epu_pkg::acc_t)) i_out_buf (
    .clk         (clk),
    .rst         (rst),
    .bus_sel_i   (out_sel),
    .bus_we_i    (out_we),
    .bus_idx_i   (out_idx),
    .bus_wdata_i (out_wdata),
    .bus_rdata_o (out_rdata),
    .eng_re_i    (1'b0),
    .eng_ridx_i  ('0),
    .eng_we_i    (eng_we),
    .eng_widx_i  (eng_widx),
    .eng_wdata_i (eng_wdata),
    .eng_rdata_o ()
  );

  epu_conv_engine i_engine (
    .clk        (clk),
    .rst        (rst),
    .start_i    (start),
    .mode_i     (mode),
    .w8_i       (w8),
    .count_i    (count),
    .in_rdata_i (eng_in_rdata),
    .wt_rdata_i (eng_wt_rdata),
    .busy_o     (busy),
    .done_o     (done),
    .rd_re_o    (eng_re),
    .rd_idx_o   (eng_ridx),
    .wr_we_o    (eng_we),
    .wr_idx_o   (eng_widx),
    .wr_data_o  (eng_wdata)
  );

endmodule

// File: verification/tb_epu.sv
`include "epu_settings.svh"

module tb_epu;

  // Generous bound over the whole directed sequence
  localparam int unsigned max_cycles = 4000;
  localparam int nwords = 16;

  logic                      clk;
  logic                      rst;
  logic                      awvalid_i, awready_o, wvalid_i, wready_o, wlast_i;
  logic                      bvalid_o, bready_i, arvalid_i, arready_o;
  logic                      rvalid_o, rready_i, rlast_o, epuint_o;
  logic [`EPU_ADDR_BITS-1:0] awaddr_i, araddr_i;
  logic [`EPU_ID_BITS-1:0]   awid_i, arid_i, bid_o, rid_o;
  logic [`EPU_LEN_BITS-1:0]  awlen_i, arlen_i;
  logic [1:0]                awburst_i, arburst_i, bresp_o, rresp_o;
  logic [`EPU_DATA_BITS-1:0] wdata_i, rdata_o;

  integer                    seed;
  int unsigned               cycles;
  logic [`EPU_DATA_BITS-1:0] wr_words [`EPU_BUF_DEPTH];
  logic [`EPU_DATA_BITS-1:0] rd_words [`EPU_BUF_DEPTH];
  // Expected buffer contents
  epu_pkg::quad_t            in_mem [`EPU_BUF_DEPTH];
  epu_pkg::quad_t            wt_mem [`EPU_BUF_DEPTH];
  epu_pkg::acc_t             out_mem [`EPU_BUF_DEPTH];

  epu_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the DUT did not finish the tests within %0d cycles", cycles);
    $display("RESULT: FAIL");
    $fatal(1, "simulation timed out");
  end

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "check failed");
  endtask

  task automatic check_quad(input epu_pkg::quad_t got, input epu_pkg::quad_t exp,
                            input string msg);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, msg, got, exp);
      abort_run();
    end
  endtask

  task automatic check_acc(input epu_pkg::acc_t got, input epu_pkg::acc_t exp,
                           input string msg);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %0d, expected %0d", $time, msg, got, exp);
      abort_run();
    end
  endtask

  task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string msg);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %b, expected %b", $time, msg, got, exp);
      abort_run();
    end
  endtask

  task automatic check_id(input logic [`EPU_ID_BITS-1:0] got,
                          input logic [`EPU_ID_BITS-1:0] exp, input string msg);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %0d, expected %0d", $time, msg, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %b, expected %b", $time, msg, got, exp);
      abort_run();
    end
  endtask

  task automatic fill_random(input int n);
    for (int b = 0; b < n; b++) begin
      wr_words[b] = $random(seed);
    end
  endtask

  task automatic axi_write_burst(input logic [`EPU_ADDR_BITS-1:0] addr,
                                 input logic [`EPU_ID_BITS-1:0] id, input int nbeats);
    @(negedge clk);
    awvalid_i = 1'b1;
    awaddr_i  = addr;
    awid_i    = id;
    awlen_i   = nbeats - 1;
    awburst_i = 2'b01;
    do @(posedge clk); while (!awready_o);
    @(negedge clk);
    awvalid_i = 1'b0;
    for (int b = 0; b < nbeats; b++) begin
      wvalid_i = 1'b1;
      wdata_i  = wr_words[b];
      wlast_i  = (b == nbeats - 1);
      do @(posedge clk); while (!wready_o);
      @(negedge clk);
    end
    wvalid_i = 1'b0;
    wlast_i  = 1'b0;
    bready_i = 1'b1;
    do @(posedge clk); while (!bvalid_o);
    check_resp(bresp_o, `EPU_RESP_OKAY, "write response code");
    check_id(bid_o, id, "write response ID");
    @(negedge clk);
    bready_i = 1'b0;
  endtask

  task automatic write_single(input logic [`EPU_ADDR_BITS-1:0] addr,
                              input logic [`EPU_ID_BITS-1:0] id,
                              input logic [`EPU_DATA_BITS-1:0] data);
    wr_words[0] = data;
    axi_write_burst(addr, id, 1);
  endtask

  // Fresh random burst into one buffer that the model mirrors
  task automatic load_region(input logic [`EPU_ADDR_BITS-1:0] base,
                             input logic [`EPU_ID_BITS-1:0] id);
    fill_random(nwords);
    axi_write_burst(base, id, nwords);
    for (int b = 0; b < nwords; b++) begin
      if (base == `EPU_IN_BASE) in_mem[b] = wr_words[b];
      else wt_mem[b] = wr_words[b];
    end
  endtask

  task automatic collect_read_beats(input logic [`EPU_ID_BITS-1:0] id, input int nbeats,
                                    input logic stall);
    integer rnd;
    logic   got;
    for (int b = 0; b < nbeats; b++) begin
      got = 1'b0;
      while (!got) begin
        rnd      = $random(seed);
        rready_i = stall ? rnd[0] : 1'b1;
        @(posedge clk);
        if (rvalid_o && rready_i) begin
          rd_words[b] = rdata_o;
          check_id(rid_o, id, $sformatf("read ID on beat %0d", b));
          check_resp(rresp_o, `EPU_RESP_OKAY, $sformatf("read response on beat %0d", b));
          check_bit(rlast_o, b == nbeats - 1, $sformatf("rlast on beat %0d", b));
          got = 1'b1;
        end
        @(negedge clk);
      end
    end
    rready_i = 1'b0;
  endtask

  task automatic axi_read_burst(input logic [`EPU_ADDR_BITS-1:0] addr,
                                input logic [`EPU_ID_BITS-1:0] id, input int nbeats,
                                input logic stall);
    @(negedge clk);
    arvalid_i = 1'b1;
    araddr_i  = addr;
    arid_i    = id;
    arlen_i   = nbeats - 1;
    arburst_i = 2'b01;
    do @(posedge clk); while (!arready_o);
    @(negedge clk);
    arvalid_i = 1'b0;
    collect_read_beats(id, nbeats, stall);
  endtask

  task automatic wait_irq();
    do @(posedge clk); while (!epuint_o);
    @(posedge clk);
    check_bit(epuint_o, 1'b0, "interrupt held past one cycle");
  endtask

  // Signed dot product over four byte lanes
  function automatic int dot_product(input logic [31:0] a, input logic [31:0] w);
    int sum;
    int x;
    int y;
    sum = 0;
    for (int l = 0; l < 4; l++) begin
      x = a[8*l +: 8];
      y = w[8*l +: 8];
      if (x > 127) x = x - 256;
      if (y > 127) y = y - 256;
      sum = sum + x * y;
    end
    return sum;
  endfunction

  task automatic compute_expected(input logic bcast, input logic relu,
                                  input epu_pkg::quad_t w8);
    int s;
    for (int b = 0; b < nwords; b++) begin
      s = dot_product(in_mem[b], bcast ? w8 : wt_mem[b]);
      if (relu && s < 0) s = 0;
      out_mem[b] = s;
    end
  endtask

  task automatic check_outputs(input logic [`EPU_ID_BITS-1:0] id);
    axi_read_burst(`EPU_OUT_BASE, id, nwords, 1'b1);
    for (int b = 0; b < nwords; b++) begin
      check_acc(rd_words[b], out_mem[b], $sformatf("output word %0d", b));
    end
  endtask

  task automatic reset_levels();
    @(negedge clk);
    check_bit(awready_o, 1'b1, "awready after reset");
    check_bit(arready_o, 1'b1, "arready after reset");
    check_bit(wready_o, 1'b0, "wready after reset");
    check_bit(bvalid_o, 1'b0, "bvalid after reset");
    check_bit(rvalid_o, 1'b0, "rvalid after reset");
    check_bit(epuint_o, 1'b0, "interrupt after reset");
  endtask

  task automatic input_round_trip();
    load_region(`EPU_IN_BASE, 4'd3);
    axi_read_burst(`EPU_IN_BASE, 4'd5, nwords, 1'b1);
    for (int b = 0; b < nwords; b++) begin
      check_quad(rd_words[b], in_mem[b], $sformatf("input buffer word %0d", b));
    end
  endtask

  task automatic weight_buffer_run();
    load_region(`EPU_IN_BASE, 4'd1);
    load_region(`EPU_WEIGHT_BASE, 4'd2);
    // Count in bits 13:8, mode 0, start in bit 0
    write_single(`EPU_CTRL_BASE + 32'd4, 4'd4, ((nwords - 1) << 8) | 32'h1);
    wait_irq();
    compute_expected(1'b0, 1'b0, '0);
    check_outputs(4'd6);
  endtask

  task automatic broadcast_relu_run();
    epu_pkg::quad_t w8;
    w8 = $random(seed);
    write_single(`EPU_CTRL_BASE, 4'd7, w8);
    // Mode 3 sits in bits 4:1
    write_single(`EPU_CTRL_BASE + 32'd4, 4'd8, ((nwords - 1) << 8) | (3 << 1) | 32'h1);
    wait_irq();
    axi_read_burst(`EPU_CTRL_BASE, 4'd10, 1, 1'b0);
    check_bit(rd_words[0][0], 1'b0, "busy in status after interrupt");
    check_bit(|rd_words[0][31:1], 1'b0, "reserved status bits");
    compute_expected(1'b1, 1'b1, w8);
    check_outputs(4'd14);
  endtask

  task automatic unmapped_access();
    axi_read_burst(32'h1000_0000, 4'd11, 1, 1'b0);
    check_quad(rd_words[0], '0, "unmapped read data");
    fill_random(4);
    axi_write_burst(32'h1000_0000, 4'd12, 4);
    axi_read_burst(`EPU_IN_BASE, 4'd13, 4, 1'b1);
    for (int b = 0; b < 4; b++) begin
      check_quad(rd_words[b], in_mem[b], $sformatf("input word %0d after unmapped write", b));
    end
    axi_read_burst(`EPU_WEIGHT_BASE, 4'd13, 4, 1'b1);
    for (int b = 0; b < 4; b++) begin
      check_quad(rd_words[b], wt_mem[b], $sformatf("weight word %0d after unmapped write", b));
    end
    axi_read_burst(`EPU_OUT_BASE, 4'd13, 4, 1'b1);
    for (int b = 0; b < 4; b++) begin
      check_acc(rd_words[b], out_mem[b], $sformatf("output word %0d after unmapped write", b));
    end
  endtask

  // Both address channels raised together so the write must finish first
  task automatic write_read_collision(input logic [`EPU_ADDR_BITS-1:0] addr,
                                      input logic [`EPU_ID_BITS-1:0] id);
    logic [`EPU_DATA_BITS-1:0] word;
    word = $random(seed);
    @(negedge clk);
    awvalid_i = 1'b1;
    awaddr_i  = addr;
    awid_i    = id;
    awlen_i   = '0;
    awburst_i = 2'b01;
    arvalid_i = 1'b1;
    araddr_i  = addr;
    arid_i    = id + 1'b1;
    arlen_i   = '0;
    arburst_i = 2'b01;
    @(posedge clk);
    check_bit(awready_o, 1'b1, "awready with both address channels valid");
    check_bit(arready_o, 1'b0, "arready while awvalid is high");
    @(negedge clk);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b1;
    wdata_i   = word;
    wlast_i   = 1'b1;
    do begin
      @(posedge clk);
      check_bit(arready_o, 1'b0, "AR accepted during the write data phase");
    end while (!wready_o);
    @(negedge clk);
    wvalid_i = 1'b0;
    wlast_i  = 1'b0;
    bready_i = 1'b1;
    do begin
      @(posedge clk);
      check_bit(arready_o, 1'b0, "AR accepted before the write response");
    end while (!bvalid_o);
    check_resp(bresp_o, `EPU_RESP_OKAY, "collision write response code");
    check_id(bid_o, id, "collision write response ID");
    @(negedge clk);
    bready_i = 1'b0;
    in_mem[addr[7:2]] = word;
    do @(posedge clk); while (!arready_o);
    @(negedge clk);
    arvalid_i = 1'b0;
    collect_read_beats(id + 1'b1, 1, 1'b0);
    check_quad(rd_words[0], in_mem[addr[7:2]], "read data after collision write");
  endtask

  initial begin
    seed      = 32'he151;
    rst       = 1'b1;
    awvalid_i = 1'b0;
    awaddr_i  = '0;
    awid_i    = '0;
    awlen_i   = '0;
    awburst_i = 2'b01;
    wvalid_i  = 1'b0;
    wdata_i   = '0;
    wlast_i   = 1'b0;
    bready_i  = 1'b0;
    arvalid_i = 1'b0;
    araddr_i  = '0;
    arid_i    = '0;
    arlen_i   = '0;
    arburst_i = 2'b01;
    rready_i  = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    reset_levels();
    input_round_trip();
    weight_buffer_run();
    broadcast_relu_run();
    unmapped_access();
    write_read_collision(`EPU_IN_BASE + 32'h40, 4'd9);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: sim.f
+incdir+include
source/epu_pkg.sv
source/epu_buffer.sv
source/epu_axi_slave.sv
source/epu_conv_engine.sv
source/epu_top.sv
verification/tb_epu.sv

// File: Bender.yml
package:
  name: epu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/epu_pkg.sv
      - source/epu_buffer.sv
      - source/epu_axi_slave.sv
      - source/epu_conv_engine.sv
      - source/epu_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/tb_epu.sv
